// ==== hdl/uart_frame_pkg.sv ====
package uart_frame_pkg;

	// Data bits in one 8N1 frame.
	localparam int DATA_BITS = 8;

	// Transmit sequencer states.
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_FETCH,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	// Receive sequencer states.
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

endpackage

// ==== hdl/uart_host_pkg.sv ====
package uart_host_pkg;

	// Host request opcodes.
	typedef enum logic [1:0] {
		OP_TX_WRITE = 2'd0,
		OP_RX_READ  = 2'd1,
		OP_STATUS   = 2'd2,
		OP_CLEAR    = 2'd3
	} host_op_t;

	// Bit positions in the status byte.
	localparam int STAT_TX_FULL  = 0;
	localparam int STAT_RX_EMPTY = 1;
	localparam int STAT_OVERRUN  = 2;
	localparam int STAT_FRAMING  = 3;
	localparam int STAT_TX_BUSY  = 4;

endpackage

// ==== hdl/byte_fifo_if.sv ====
`timescale 1ns/1ps

interface byte_fifo_if;

	logic       push;
	logic [7:0] push_data;
	logic       full;
	logic       pop;
	logic [7:0] pop_data;
	logic       empty;

	// Producer side.
	modport writer (output push, output push_data, input full);

	// Consumer side.
	modport reader (output pop, input pop_data, input empty);

	modport fifo (
		input  push, push_data, pop,
		output full, pop_data, empty
	);

endinterface

// ==== hdl/byte_fifo.sv ====
`timescale 1ns/1ps

module byte_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic     i_clock,
	input  logic     i_rst_n,
	byte_fifo_if.fifo io_bus
);

	localparam int ADDR_W = $clog2(FIFO_DEPTH);

	logic [7:0]      mem [FIFO_DEPTH];
	logic [ADDR_W:0] wr_ptr;
	logic [ADDR_W:0] rd_ptr;
	logic [ADDR_W:0] rd_next;
	logic            do_push;
	logic            do_pop;

	// Extra pointer bit tells full from empty.
	assign io_bus.empty = (wr_ptr == rd_ptr);
	assign io_bus.full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
		(wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

	assign do_push = io_bus.push && !io_bus.full;
	assign do_pop  = io_bus.pop && !io_bus.empty;
	assign rd_next = rd_ptr + {{ADDR_W{1'b0}}, do_pop};

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			wr_ptr <= wr_ptr + {{ADDR_W{1'b0}}, do_push};
			rd_ptr <= rd_next;
		end
	end

	always_ff @(posedge i_clock) begin
		if (do_push)
			mem[wr_ptr[ADDR_W-1:0]] <= io_bus.push_data;
	end

	// Registered head. A push into an empty FIFO bypasses the array.
	always_ff @(posedge i_clock) begin
		if (do_push && (wr_ptr[ADDR_W-1:0] == rd_next[ADDR_W-1:0]))
			io_bus.pop_data <= io_bus.push_data;
		else
			io_bus.pop_data <= mem[rd_next[ADDR_W-1:0]];
	end

endmodule

// ==== hdl/uart_host_front.sv ====
`timescale 1ns/1ps

module uart_host_front
	import uart_host_pkg::*;
(
	input  logic         i_clock,
	input  logic         i_rst_n,
	input  logic         i_request,
	input  host_op_t     i_opcode,
	input  logic [7:0]   i_wdata,
	input  logic         i_frame_err,
	input  logic         i_overrun,
	input  logic         i_tx_busy,
	output logic         o_ready,
	output logic [7:0]   o_rdata,
	byte_fifo_if.writer  tx_bus,
	byte_fifo_if.reader  rx_bus
);

	typedef enum logic {
		FRONT_IDLE,
		FRONT_ACK
	} front_state_t;

	front_state_t state;
	logic         accept;
	logic         overrun_flag;
	logic         framing_flag;
	logic [7:0]   status;

	// A write is held off while the tx FIFO is full.
	assign accept = (state == FRONT_IDLE) && i_request &&
		((i_opcode != OP_TX_WRITE) || !tx_bus.full);

	assign o_ready = (state == FRONT_ACK);

	always_comb begin
		status = '0;
		status[STAT_TX_FULL]  = tx_bus.full;
		status[STAT_RX_EMPTY] = rx_bus.empty;
		status[STAT_OVERRUN]  = overrun_flag;
		status[STAT_FRAMING]  = framing_flag;
		status[STAT_TX_BUSY]  = i_tx_busy;
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state       <= FRONT_IDLE;
			tx_bus.push <= 1'b0;
			rx_bus.pop  <= 1'b0;
			o_rdata     <= '0;
		end else begin
			tx_bus.push <= 1'b0;
			rx_bus.pop  <= 1'b0;
			state       <= accept ? FRONT_ACK : FRONT_IDLE;
			if (accept) begin
				case (i_opcode)
					OP_TX_WRITE: tx_bus.push <= 1'b1;
					OP_RX_READ: begin
						rx_bus.pop <= !rx_bus.empty;
						o_rdata    <= rx_bus.empty ? 8'h00 : rx_bus.pop_data;
					end
					OP_STATUS: o_rdata <= status;
					default: o_rdata <= '0;
				endcase
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept && (i_opcode == OP_TX_WRITE))
			tx_bus.push_data <= i_wdata;
	end

	// Sticky flags. A new error beats a clear in the same cycle.
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			overrun_flag <= 1'b0;
			framing_flag <= 1'b0;
		end else begin
			if (accept && (i_opcode == OP_CLEAR)) begin
				overrun_flag <= 1'b0;
				framing_flag <= 1'b0;
			end
			if (i_overrun)
				overrun_flag <= 1'b1;
			if (i_frame_err)
				framing_flag <= 1'b1;
		end
	end

endmodule

// ==== hdl/uart_serializer.sv ====
`timescale 1ns/1ps

module uart_serializer
	import uart_frame_pkg::*;
#(
	parameter int CLOCK_FREQ = 50_000_000,
	parameter int BAUD_RATE  = 115_200
) (
	input  logic        i_clock,
	input  logic        i_rst_n,
	output logic        o_tx,
	output logic        o_busy,
	byte_fifo_if.reader fifo_bus
);

	localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
	localparam int CNT_W        = $clog2(CLKS_PER_BIT);
	localparam int IDX_W        = $clog2(DATA_BITS);

	tx_state_t            state;
	logic [CNT_W-1:0]     baud_cnt;
	logic [IDX_W-1:0]     bit_idx;
	logic [DATA_BITS-1:0] shift_reg;
	logic                 bit_done;

	assign bit_done = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));

	// Head byte leaves the FIFO during FETCH.
	assign fifo_bus.pop = (state == TX_FETCH);
	assign o_busy       = (state != TX_IDLE);

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state    <= TX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			o_tx     <= 1'b1;
		end else begin
			// Bit timer restarts with every frame.
			if ((state == TX_IDLE) || (state == TX_FETCH) || bit_done)
				baud_cnt <= '0;
			else
				baud_cnt <= baud_cnt + 1'b1;

			case (state)
				TX_IDLE: begin
					if (!fifo_bus.empty)
						state <= TX_FETCH;
				end
				TX_FETCH: begin
					o_tx  <= 1'b0;
					state <= TX_START;
				end
				TX_START: begin
					if (bit_done) begin
						o_tx    <= shift_reg[0];
						bit_idx <= '0;
						state   <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (bit_done) begin
						if (bit_idx == IDX_W'(DATA_BITS - 1)) begin
							o_tx  <= 1'b1;
							state <= TX_STOP;
						end else begin
							o_tx    <= shift_reg[0];
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				TX_STOP: begin
					// Go straight to the next byte if one is waiting.
					if (bit_done)
						state <= fifo_bus.empty ? TX_IDLE : TX_FETCH;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// LSB first.
	always_ff @(posedge i_clock) begin
		if (state == TX_FETCH)
			shift_reg <= fifo_bus.pop_data;
		else if (bit_done && ((state == TX_START) || (state == TX_DATA)))
			shift_reg <= shift_reg >> 1;
	end

endmodule

// ==== hdl/uart_deserializer.sv ====
`timescale 1ns/1ps

module uart_deserializer
	import uart_frame_pkg::*;
#(
	parameter int CLOCK_FREQ = 50_000_000,
	parameter int BAUD_RATE  = 115_200
) (
	input  logic        i_clock,
	input  logic        i_rst_n,
	input  logic        i_rx,
	output logic        o_frame_err,
	output logic        o_overrun,
	byte_fifo_if.writer fifo_bus
);

	localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;
	localparam int HALF_BIT     = CLKS_PER_BIT / 2;
	localparam int CNT_W        = $clog2(CLKS_PER_BIT);
	localparam int IDX_W        = $clog2(DATA_BITS);

	rx_state_t            state;
	logic [CNT_W-1:0]     baud_cnt;
	logic [IDX_W-1:0]     bit_idx;
	logic [DATA_BITS-1:0] shift_reg;
	logic                 rx_meta;
	logic                 rx_sync;
	logic                 rx_prev;
	logic                 bit_done;

	assign bit_done         = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign fifo_bus.push_data = shift_reg;

	// Two-flop synchronizer plus one flop for edge detection.
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state         <= RX_IDLE;
			baud_cnt      <= '0;
			bit_idx       <= '0;
			fifo_bus.push <= 1'b0;
			o_frame_err   <= 1'b0;
			o_overrun     <= 1'b0;
		end else begin
			fifo_bus.push <= 1'b0;
			o_frame_err   <= 1'b0;
			o_overrun     <= 1'b0;
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					if (rx_prev && !rx_sync)
						state <= RX_START;
				end
				RX_START: begin
					// Recheck at mid start bit to reject glitches.
					if (baud_cnt == CNT_W'(HALF_BIT - 1)) begin
						baud_cnt <= '0;
						bit_idx  <= '0;
						state    <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_done) begin
						baud_cnt <= '0;
						if (bit_idx == IDX_W'(DATA_BITS - 1))
							state <= RX_STOP;
						else
							bit_idx <= bit_idx + 1'b1;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (bit_done) begin
						baud_cnt <= '0;
						state    <= RX_IDLE;
						if (!rx_sync)
							o_frame_err <= 1'b1;
						else if (fifo_bus.full)
							o_overrun <= 1'b1;
						else
							fifo_bus.push <= 1'b1;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Data arrives LSB first.
	always_ff @(posedge i_clock) begin
		if ((state == RX_DATA) && bit_done)
			shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
	end

endmodule

// ==== hdl/uart_top.sv ====
`timescale 1ns/1ps

module uart_top
	import uart_host_pkg::*;
#(
	parameter int CLOCK_FREQ = 50_000_000,
	parameter int BAUD_RATE  = 115_200,
	parameter int FIFO_DEPTH = 16
) (
	input  logic       i_clock,
	input  logic       i_rst_n,
	input  logic       i_request,
	input  logic [1:0] i_opcode,
	input  logic [7:0] i_wdata,
	input  logic       i_rx,
	output logic       o_ready,
	output logic [7:0] o_rdata,
	output logic       o_tx
);

	logic tx_busy;
	logic frame_err;
	logic overrun;

	byte_fifo_if tx_fifo_bus ();
	byte_fifo_if rx_fifo_bus ();

	byte_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) tx_fifo (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.io_bus (tx_fifo_bus)
	);

	byte_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) rx_fifo (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.io_bus (rx_fifo_bus)
	);

	uart_host_front host_front (
		.i_clock    (i_clock),
		.i_rst_n    (i_rst_n),
		.i_request  (i_request),
		.i_opcode   (host_op_t'(i_opcode)),
		.i_wdata    (i_wdata),
		.i_frame_err(frame_err),
		.i_overrun  (overrun),
		.i_tx_busy  (tx_busy),
		.o_ready    (o_ready),
		.o_rdata    (o_rdata),
		.tx_bus     (tx_fifo_bus),
		.rx_bus     (rx_fifo_bus)
	);

	uart_serializer #(
		.CLOCK_FREQ(CLOCK_FREQ),
		.BAUD_RATE (BAUD_RATE)
	) serializer (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.o_tx    (o_tx),
		.o_busy  (tx_busy),
		.fifo_bus(tx_fifo_bus)
	);

	uart_deserializer #(
		.CLOCK_FREQ(CLOCK_FREQ),
		.BAUD_RATE (BAUD_RATE)
	) deserializer (
		.i_clock    (i_clock),
		.i_rst_n    (i_rst_n),
		.i_rx       (i_rx),
		.o_frame_err(frame_err),
		.o_overrun  (overrun),
		.fifo_bus   (rx_fifo_bus)
	);

endmodule

// ==== sim/uart_tb.sv ====
`timescale 1ns/1ps

module uart_tb
	import uart_host_pkg::*;
();

	localparam int CLOCK_FREQ  = 10_000_000;
	localparam int BAUD_RATE   = 1_000_000;
	localparam int BIT_CYCLES  = CLOCK_FREQ / BAUD_RATE;
	localparam int READY_LIMIT = 300;
	localparam int POLL_LIMIT  = 200;
	// About 36 frames of 100 cycles plus polling and margin.
	localparam int CYCLE_LIMIT = 8000;

	localparam logic [7:0] RX_EMPTY_BIT = 8'(1 << STAT_RX_EMPTY);
	localparam logic [7:0] OVERRUN_BIT  = 8'(1 << STAT_OVERRUN);
	localparam logic [7:0] FRAMING_BIT  = 8'(1 << STAT_FRAMING);
	localparam logic [7:0] TX_BUSY_BIT  = 8'(1 << STAT_TX_BUSY);

	logic       clock;
	logic       rst_n;
	logic       request;
	logic [1:0] opcode;
	logic [7:0] wdata;
	logic       ready;
	logic [7:0] rdata;
	logic       tx_line;
	logic       rx_line;
	logic       drv_line;
	logic       loopback;
	int         errors;
	int         cycle_count;
	int         seed;
	logic [7:0] expected_q[$];

	// Loopback feeds the transmitter straight into the receiver.
	assign rx_line = loopback ? tx_line : drv_line;

	uart_top #(
		.CLOCK_FREQ(CLOCK_FREQ),
		.BAUD_RATE (BAUD_RATE),
		.FIFO_DEPTH(16)
	) UUT (
		.i_clock  (clock),
		.i_rst_n  (rst_n),
		.i_request(request),
		.i_opcode (opcode),
		.i_wdata  (wdata),
		.i_rx     (rx_line),
		.o_ready  (ready),
		.o_rdata  (rdata),
		.o_tx     (tx_line)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [7:0] actual,
		input logic [7:0] expected);
		if (actual !== expected) begin
			errors++;
			$display("mismatch at %0t: %s is 0x%02h, expected 0x%02h",
				$time, name, actual, expected);
		end
	endtask

	// One request, held until ready pulses.
	task automatic host_op(input host_op_t op, input logic [7:0] data,
		output logic [7:0] result);
		int waited;
		waited = 0;
		@(posedge clock);
		request <= 1'b1;
		opcode  <= op;
		wdata   <= data;
		@(negedge clock);
		while (!ready && waited < READY_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (!ready) begin
			errors++;
			$display("Host request with opcode %0d was never acknowledged", op);
		end
		result = rdata;
		@(posedge clock);
		request <= 1'b0;
	endtask

	task automatic wait_rx();
		logic [7:0] status;
		int polls;
		polls = 0;
		do begin
			host_op(OP_STATUS, 8'h00, status);
			polls++;
		end while (status[STAT_RX_EMPTY] && polls < POLL_LIMIT);
		if (status[STAT_RX_EMPTY]) begin
			errors++;
			$display("No byte arrived in the receive FIFO");
		end
	endtask

	task automatic wait_tx_idle();
		logic [7:0] status;
		int polls;
		polls = 0;
		do begin
			host_op(OP_STATUS, 8'h00, status);
			polls++;
		end while (status[STAT_TX_BUSY] && polls < POLL_LIMIT * 4);
		if (status[STAT_TX_BUSY]) begin
			errors++;
			$display("Transmitter never went idle");
		end
		// Receiver pushes within one bit after the stop bit midpoint.
		repeat (2 * BIT_CYCLES) @(posedge clock);
	endtask

	task automatic drive_bit(input logic value);
		@(posedge clock);
		drv_line <= value;
		repeat (BIT_CYCLES - 1) @(posedge clock);
	endtask

	// 8N1 frame on the driven line, LSB first, then two idle bits.
	task automatic drive_frame(input logic [7:0] data, input logic stop_bit);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < 8; i++)
			drive_bit(data[i]);
		drive_bit(stop_bit);
		drive_bit(1'b1);
		drive_bit(1'b1);
	endtask

	task automatic write_random(input int count);
		logic [7:0] data;
		logic [7:0] unused;
		int i;
		for (i = 0; i < count; i++) begin
			data = 8'($random(seed));
			expected_q.push_back(data);
			host_op(OP_TX_WRITE, data, unused);
		end
	endtask

	task automatic reset_state_test();
		logic [7:0] result;
		@(negedge clock);
		check_value("o_tx", {7'd0, tx_line}, 8'h01);
		host_op(OP_STATUS, 8'h00, result);
		check_value("status", result, RX_EMPTY_BIT);
		host_op(OP_RX_READ, 8'h00, result);
		check_value("o_rdata", result, 8'h00);
	endtask

	task automatic single_byte_test();
		logic [7:0] result;
		host_op(OP_TX_WRITE, 8'hA5, result);
		host_op(OP_STATUS, 8'h00, result);
		check_value("status", result, TX_BUSY_BIT | RX_EMPTY_BIT);
		wait_rx();
		host_op(OP_RX_READ, 8'h00, result);
		check_value("o_rdata", result, 8'hA5);
	endtask

	task automatic stream_test();
		logic [7:0] result;
		int i;
		write_random(16);
		for (i = 0; i < 16; i++) begin
			wait_rx();
			host_op(OP_RX_READ, 8'h00, result);
			check_value("o_rdata", result, expected_q.pop_front());
		end
	endtask

	task automatic overrun_test();
		logic [7:0] result;
		int i;
		write_random(18);
		wait_tx_idle();
		host_op(OP_STATUS, 8'h00, result);
		check_value("status", result, OVERRUN_BIT);
		for (i = 0; i < 16; i++) begin
			host_op(OP_RX_READ, 8'h00, result);
			check_value("o_rdata", result, expected_q.pop_front());
		end
		expected_q.delete();
		host_op(OP_CLEAR, 8'h00, result);
		host_op(OP_STATUS, 8'h00, result);
		check_value("status", result, RX_EMPTY_BIT);
	endtask

	task automatic framing_test();
		logic [7:0] result;
		@(posedge clock);
		loopback <= 1'b0;
		drive_frame(8'h5A, 1'b0);
		host_op(OP_STATUS, 8'h00, result);
		check_value("status", result, FRAMING_BIT | RX_EMPTY_BIT);
		host_op(OP_CLEAR, 8'h00, result);
		host_op(OP_STATUS, 8'h00, result);
		check_value("status", result, RX_EMPTY_BIT);
		drive_frame(8'h3C, 1'b1);
		wait_rx();
		host_op(OP_RX_READ, 8'h00, result);
		check_value("o_rdata", result, 8'h3C);
	endtask

	initial begin
		rst_n       = 1'b0;
		request     = 1'b0;
		opcode      = 2'd0;
		wdata       = 8'h00;
		drv_line    = 1'b1;
		loopback    = 1'b1;
		errors      = 0;
		cycle_count = 0;
		seed        = 12874;
		repeat (16) @(posedge clock);
		rst_n <= 1'b1;
		reset_state_test();
		single_byte_test();
		stream_test();
		overrun_test();
		framing_test();
		$display("Checks done with %0d errors", errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== sources.f ====
hdl/uart_frame_pkg.sv
hdl/uart_host_pkg.sv
hdl/byte_fifo_if.sv
hdl/byte_fifo.sv
hdl/uart_host_front.sv
hdl/uart_serializer.sv
hdl/uart_deserializer.sv
hdl/uart_top.sv
sim/uart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary -f sources.f --top-module uart_tb

output=$(./obj_dir/Vuart_tb)
echo "$output"

if echo "$output" | grep -q "Test completed successfully"; then
	exit 0
else
	exit 1
fi
